// File: logic/cp0_reg_pkg.sv
package cp0_reg_pkg;

    typedef logic [31:0] word_t;

    // Register number in [7:3], select in [2:0]
    typedef logic [7:0] cp0_addr_t;

    localparam cp0_addr_t CP0_BADVADDR = {5'd8, 3'd0};
    localparam cp0_addr_t CP0_COUNT    = {5'd9, 3'd0};
    localparam cp0_addr_t CP0_COMPARE  = {5'd11, 3'd0};
    localparam cp0_addr_t CP0_STATUS   = {5'd12, 3'd0};
    localparam cp0_addr_t CP0_CAUSE    = {5'd13, 3'd0};
    localparam cp0_addr_t CP0_EPC      = {5'd14, 3'd0};
    localparam cp0_addr_t CP0_PRID     = {5'd15, 3'd0};
    localparam cp0_addr_t CP0_EBASE    = {5'd15, 3'd1};
    localparam cp0_addr_t CP0_CONFIG   = {5'd16, 3'd0};
    localparam cp0_addr_t CP0_CONFIG1  = {5'd16, 3'd1};

    // Status fields
    localparam int STATUS_CU0   = 28;
    localparam int STATUS_BEV   = 22;
    localparam int STATUS_IM_HI = 15;
    localparam int STATUS_IM_LO = 8;
    localparam int STATUS_UM    = 4;
    localparam int STATUS_ERL   = 2;
    localparam int STATUS_EXL   = 1;
    localparam int STATUS_IE    = 0;

    // Cause fields
    localparam int CAUSE_BD         = 31;
    localparam int CAUSE_TI         = 30;
    localparam int CAUSE_IV         = 23;
    localparam int CAUSE_WP         = 22;
    localparam int CAUSE_IP_HW_HI   = 15;
    localparam int CAUSE_IP_HW_LO   = 10;
    localparam int CAUSE_IP_SW_HI   = 9;
    localparam int CAUSE_IP_SW_LO   = 8;
    localparam int CAUSE_EXCCODE_HI = 6;
    localparam int CAUSE_EXCCODE_LO = 2;

    // Kernel mode with boot vectors and error level
    localparam word_t STATUS_RESET = 32'h1040_0004;
    // M set, MT fixed mapping, kseg0 cacheable
    localparam word_t CONFIG_RESET = 32'h8000_0183;
    // No Config2, no TLB, 64 sets of 16 bytes in 4 ways for I and D
    localparam word_t CONFIG1_VALUE = {1'b0, 6'd0, 3'd0, 3'd3, 3'd3, 3'd0, 3'd3, 3'd3, 7'd0};
    localparam word_t EBASE_RESET = 32'h8000_0000;

endpackage

// File: logic/cp0_exc_pkg.sv
package cp0_exc_pkg;

    // Exception kinds as signalled by the pipeline
    typedef enum logic [4:0] {
        EXC_NONE      = 5'd0,
        EXC_INT       = 5'd1,
        EXC_ADEL_DATA = 5'd4,
        EXC_ADES      = 5'd5,
        EXC_SYS       = 5'd8,
        EXC_BP        = 5'd9,
        EXC_RI        = 5'd10,
        EXC_OV        = 5'd12,
        EXC_TR        = 5'd13,
        EXC_ERET      = 5'd14,
        EXC_ADEL_INST = 5'd15
    } exc_type_t;

    // Architectural ExcCode field of Cause
    typedef logic [4:0] exccode_t;

    localparam exccode_t EXCCODE_INT  = 5'd0;
    localparam exccode_t EXCCODE_ADEL = 5'd4;
    localparam exccode_t EXCCODE_ADES = 5'd5;
    localparam exccode_t EXCCODE_SYS  = 5'd8;
    localparam exccode_t EXCCODE_BP   = 5'd9;
    localparam exccode_t EXCCODE_RI   = 5'd10;
    localparam exccode_t EXCCODE_OV   = 5'd12;
    localparam exccode_t EXCCODE_TR   = 5'd13;

    // Offsets added to the vector base
    localparam logic [31:0] VEC_OFS_GENERAL = 32'h0000_0180;
    localparam logic [31:0] VEC_OFS_INT_IV  = 32'h0000_0200;

endpackage

// File: logic/cp0_timer.sv
module cp0_timer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   we_i,
    input  cp0_reg_pkg::cp0_addr_t waddr_i,
    input  cp0_reg_pkg::word_t     data_i,
    output cp0_reg_pkg::word_t     count_o,
    output cp0_reg_pkg::word_t     compare_o,
    output logic                   timer_int_o
);
    import cp0_reg_pkg::*;

    logic count_we;
    logic compare_we;
    logic match;

    assign count_we   = we_i && (waddr_i == CP0_COUNT);
    assign compare_we = we_i && (waddr_i == CP0_COMPARE);

    // Compare of zero never fires
    assign match = (compare_o != '0) && (count_o == compare_o);

    always_ff @(posedge clk) begin
        if (rst) begin
            count_o     <= '0;
            compare_o   <= '0;
            timer_int_o <= 1'b0;
        end else begin
            // Software write takes the place of the increment
            if (count_we) begin
                count_o <= data_i;
            end else begin
                count_o <= count_o + 32'd1;
            end

            if (compare_we) begin
                compare_o <= data_i;
            end

            // Writing Compare acknowledges the interrupt
            if (compare_we) begin
                timer_int_o <= 1'b0;
            end else if (match) begin
                timer_int_o <= 1'b1;
            end
        end
    end

endmodule

// File: logic/cp0_status_cause.sv
module cp0_status_cause (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [5:0]             int_i,
    input  logic                   we_i,
    input  cp0_reg_pkg::cp0_addr_t waddr_i,
    input  cp0_reg_pkg::word_t     data_i,
    input  logic                   timer_int_i,
    input  cp0_exc_pkg::exc_type_t except_type_i,
    input  cp0_reg_pkg::word_t     pc_i,
    input  logic                   in_delay_slot_i,
    input  cp0_reg_pkg::word_t     mem_addr_i,
    output cp0_reg_pkg::word_t     status_o,
    output cp0_reg_pkg::word_t     cause_o,
    output cp0_reg_pkg::word_t     epc_o,
    output cp0_reg_pkg::word_t     badvaddr_o,
    output logic                   user_mode_o
);
    import cp0_reg_pkg::*;
    import cp0_exc_pkg::*;

    // Status bits open to software
    localparam word_t STATUS_WMASK = (word_t'(1) << STATUS_CU0)
                                   | (word_t'(1) << STATUS_BEV)
                                   | (word_t'(8'hff) << STATUS_IM_LO)
                                   | (word_t'(1) << STATUS_UM)
                                   | (word_t'(1) << STATUS_ERL)
                                   | (word_t'(1) << STATUS_EXL)
                                   | (word_t'(1) << STATUS_IE);

    logic       status_we;
    logic       cause_we;
    logic       epc_we;
    logic       cause_bd;
    logic       cause_iv;
    logic       cause_wp;
    logic [5:0] cause_ip_hw;
    logic [1:0] cause_ip_sw;
    exccode_t   cause_exccode;
    logic       exc_taken;
    exccode_t   exc_code;
    logic       bad_from_mem;
    logic       bad_from_pc;

    assign status_we = we_i && (waddr_i == CP0_STATUS);
    assign cause_we  = we_i && (waddr_i == CP0_CAUSE);
    assign epc_we    = we_i && (waddr_i == CP0_EPC);

    // Map exception kind to ExcCode; ERET and none are not entries
    always_comb begin
        exc_taken = 1'b1;
        exc_code  = EXCCODE_INT;
        case (except_type_i)
            EXC_INT:       exc_code = EXCCODE_INT;
            EXC_ADEL_DATA: exc_code = EXCCODE_ADEL;
            EXC_ADEL_INST: exc_code = EXCCODE_ADEL;
            EXC_ADES:      exc_code = EXCCODE_ADES;
            EXC_SYS:       exc_code = EXCCODE_SYS;
            EXC_BP:        exc_code = EXCCODE_BP;
            EXC_RI:        exc_code = EXCCODE_RI;
            EXC_OV:        exc_code = EXCCODE_OV;
            EXC_TR:        exc_code = EXCCODE_TR;
            default:       exc_taken = 1'b0;
        endcase
    end

    assign bad_from_mem = (except_type_i == EXC_ADEL_DATA) || (except_type_i == EXC_ADES);
    assign bad_from_pc  = (except_type_i == EXC_ADEL_INST);

    always_ff @(posedge clk) begin
        if (rst) begin
            status_o      <= STATUS_RESET;
            cause_bd      <= 1'b0;
            cause_iv      <= 1'b0;
            cause_wp      <= 1'b0;
            cause_ip_hw   <= '0;
            cause_ip_sw   <= '0;
            cause_exccode <= EXCCODE_INT;
        end else begin
            // Hardware interrupt lines sampled every cycle
            cause_ip_hw <= int_i;

            if (status_we) begin
                status_o <= (status_o & ~STATUS_WMASK) | (data_i & STATUS_WMASK);
            end

            if (cause_we) begin
                cause_ip_sw <= data_i[CAUSE_IP_SW_HI:CAUSE_IP_SW_LO];
                cause_iv    <= data_i[CAUSE_IV];
                cause_wp    <= data_i[CAUSE_WP];
            end

            // Exception updates come last so they override software writes
            if (exc_taken) begin
                if (!status_o[STATUS_EXL]) begin
                    cause_bd <= in_delay_slot_i;
                end
                status_o[STATUS_EXL] <= 1'b1;
                cause_exccode        <= exc_code;
            end else if (except_type_i == EXC_ERET) begin
                status_o[STATUS_EXL] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (epc_we) begin
            epc_o <= data_i;
        end
        // Nested exceptions keep the first EPC
        if (exc_taken && !status_o[STATUS_EXL]) begin
            epc_o <= in_delay_slot_i ? pc_i - 32'd4 : pc_i;
        end

        if (bad_from_mem) begin
            badvaddr_o <= mem_addr_i;
        end else if (bad_from_pc) begin
            badvaddr_o <= pc_i;
        end
    end

    always_comb begin
        cause_o                                    = '0;
        cause_o[CAUSE_BD]                          = cause_bd;
        cause_o[CAUSE_TI]                          = timer_int_i;
        cause_o[CAUSE_IV]                          = cause_iv;
        cause_o[CAUSE_WP]                          = cause_wp;
        cause_o[CAUSE_IP_HW_HI:CAUSE_IP_HW_LO]     = cause_ip_hw;
        cause_o[CAUSE_IP_SW_HI:CAUSE_IP_SW_LO]     = cause_ip_sw;
        cause_o[CAUSE_EXCCODE_HI:CAUSE_EXCCODE_LO] = cause_exccode;
    end

    // User mode only outside exception and error level
    assign user_mode_o = status_o[STATUS_UM] && !status_o[STATUS_EXL] && !status_o[STATUS_ERL];

endmodule

// File: logic/cp0_config_regs.sv
module cp0_config_regs #(
    parameter cp0_reg_pkg::word_t PRID_VALUE = 32'h0001_8000
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   we_i,
    input  cp0_reg_pkg::cp0_addr_t waddr_i,
    input  cp0_reg_pkg::word_t     data_i,
    output cp0_reg_pkg::word_t     ebase_o,
    output cp0_reg_pkg::word_t     config_o,
    output cp0_reg_pkg::word_t     config1_o,
    output cp0_reg_pkg::word_t     prid_o
);
    import cp0_reg_pkg::*;

    // Exception base field of EBase
    localparam int EBASE_BASE_HI = 29;
    localparam int EBASE_BASE_LO = 12;
    // kseg0 cacheability field of Config
    localparam int CONFIG_K0_HI = 2;
    localparam int CONFIG_K0_LO = 0;

    logic ebase_we;
    logic config_we;

    assign ebase_we  = we_i && (waddr_i == CP0_EBASE);
    assign config_we = we_i && (waddr_i == CP0_CONFIG);

    always_ff @(posedge clk) begin
        if (rst) begin
            ebase_o  <= EBASE_RESET;
            config_o <= CONFIG_RESET;
        end else begin
            if (ebase_we) begin
                ebase_o[EBASE_BASE_HI:EBASE_BASE_LO] <= data_i[EBASE_BASE_HI:EBASE_BASE_LO];
            end
            if (config_we) begin
                config_o[CONFIG_K0_HI:CONFIG_K0_LO] <= data_i[CONFIG_K0_HI:CONFIG_K0_LO];
            end
        end
    end

    // Read-only identification words
    assign prid_o    = PRID_VALUE;
    assign config1_o = CONFIG1_VALUE;

endmodule

// File: logic/cp0_read_mux.sv
module cp0_read_mux (
    input  cp0_reg_pkg::cp0_addr_t raddr_i,
    input  cp0_reg_pkg::word_t     count_i,
    input  cp0_reg_pkg::word_t     compare_i,
    input  cp0_reg_pkg::word_t     status_i,
    input  cp0_reg_pkg::word_t     cause_i,
    input  cp0_reg_pkg::word_t     epc_i,
    input  cp0_reg_pkg::word_t     badvaddr_i,
    input  cp0_reg_pkg::word_t     ebase_i,
    input  cp0_reg_pkg::word_t     config_i,
    input  cp0_reg_pkg::word_t     config1_i,
    input  cp0_reg_pkg::word_t     prid_i,
    output cp0_reg_pkg::word_t     data_o
);
    import cp0_reg_pkg::*;

    // Unimplemented registers read as zero
    always_comb begin
        case (raddr_i)
            CP0_BADVADDR: data_o = badvaddr_i;
            CP0_COUNT:    data_o = count_i;
            CP0_COMPARE:  data_o = compare_i;
            CP0_STATUS:   data_o = status_i;
            CP0_CAUSE:    data_o = cause_i;
            CP0_EPC:      data_o = epc_i;
            CP0_PRID:     data_o = prid_i;
            CP0_EBASE:    data_o = ebase_i;
            CP0_CONFIG:   data_o = config_i;
            CP0_CONFIG1:  data_o = config1_i;
            default:      data_o = '0;
        endcase
    end

endmodule

// File: logic/cp0_vector.sv
module cp0_vector #(
    parameter cp0_reg_pkg::word_t BOOT_EXC_BASE = 32'hbfc0_0200
) (
    input  cp0_exc_pkg::exc_type_t except_type_i,
    input  cp0_reg_pkg::word_t     status_i,
    input  cp0_reg_pkg::word_t     cause_i,
    input  cp0_reg_pkg::word_t     ebase_i,
    input  cp0_reg_pkg::word_t     epc_i,
    output cp0_reg_pkg::word_t     exception_vector_o
);
    import cp0_reg_pkg::*;
    import cp0_exc_pkg::*;

    word_t vec_base;
    word_t vec_ofs;

    always_comb begin
        // Boot vectors while BEV is set
        vec_base = status_i[STATUS_BEV] ? BOOT_EXC_BASE : {ebase_i[31:12], 12'h000};

        vec_ofs = VEC_OFS_GENERAL;
        if (except_type_i == EXC_INT && cause_i[CAUSE_IV]) begin
            vec_ofs = VEC_OFS_INT_IV;
        end

        exception_vector_o = vec_base + vec_ofs;

        // Return target instead of a handler
        if (except_type_i == EXC_ERET) begin
            exception_vector_o = epc_i;
        end
    end

endmodule

// File: logic/cp0_top.sv
module cp0_top #(
    parameter cp0_reg_pkg::word_t PRID_VALUE    = 32'h0001_8000,
    parameter cp0_reg_pkg::word_t BOOT_EXC_BASE = 32'hbfc0_0200
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [5:0]             int_i,
    input  logic                   we_i,
    input  cp0_reg_pkg::cp0_addr_t waddr_i,
    input  cp0_reg_pkg::cp0_addr_t raddr_i,
    input  cp0_reg_pkg::word_t     data_i,
    input  cp0_exc_pkg::exc_type_t except_type_i,
    input  cp0_reg_pkg::word_t     pc_i,
    input  logic                   in_delay_slot_i,
    input  cp0_reg_pkg::word_t     mem_addr_i,
    output cp0_reg_pkg::word_t     data_o,
    output cp0_reg_pkg::word_t     status_o,
    output cp0_reg_pkg::word_t     cause_o,
    output cp0_reg_pkg::word_t     epc_o,
    output cp0_reg_pkg::word_t     exception_vector_o,
    output logic                   user_mode_o,
    output logic                   timer_int_o
);
    import cp0_reg_pkg::*;

    word_t count;
    word_t compare;
    word_t badvaddr;
    word_t ebase;
    word_t config_w;
    word_t config1;
    word_t prid;

    cp0_timer cp0_timer_inst (
        .clk         (clk),
        .rst         (rst),
        .we_i        (we_i),
        .waddr_i     (waddr_i),
        .data_i      (data_i),
        .count_o     (count),
        .compare_o   (compare),
        .timer_int_o (timer_int_o)
    );

    cp0_status_cause cp0_status_cause_inst (
        .clk             (clk),
        .rst             (rst),
        .int_i           (int_i),
        .we_i            (we_i),
        .waddr_i         (waddr_i),
        .data_i          (data_i),
        .timer_int_i     (timer_int_o),
        .except_type_i   (except_type_i),
        .pc_i            (pc_i),
        .in_delay_slot_i (in_delay_slot_i),
        .mem_addr_i      (mem_addr_i),
        .status_o        (status_o),
        .cause_o         (cause_o),
        .epc_o           (epc_o),
        .badvaddr_o      (badvaddr),
        .user_mode_o     (user_mode_o)
    );

    cp0_config_regs #(
        .PRID_VALUE (PRID_VALUE)
    ) cp0_config_regs_inst (
        .clk       (clk),
        .rst       (rst),
        .we_i      (we_i),
        .waddr_i   (waddr_i),
        .data_i    (data_i),
        .ebase_o   (ebase),
        .config_o  (config_w),
        .config1_o (config1),
        .prid_o    (prid)
    );

    cp0_read_mux cp0_read_mux_inst (
        .raddr_i    (raddr_i),
        .count_i    (count),
        .compare_i  (compare),
        .status_i   (status_o),
        .cause_i    (cause_o),
        .epc_i      (epc_o),
        .badvaddr_i (badvaddr),
        .ebase_i    (ebase),
        .config_i   (config_w),
        .config1_i  (config1),
        .prid_i     (prid),
        .data_o     (data_o)
    );

    cp0_vector #(
        .BOOT_EXC_BASE (BOOT_EXC_BASE)
    ) cp0_vector_inst (
        .except_type_i      (except_type_i),
        .status_i           (status_o),
        .cause_i            (cause_o),
        .ebase_i            (ebase),
        .epc_i              (epc_o),
        .exception_vector_o (exception_vector_o)
    );

endmodule

// File: bench/cp0_tb_tasks.svh
// Status, Cause, EBase and Config bits that software can change
localparam word_t STATUS_SW_MASK = 32'h1040_ff17;
localparam word_t CAUSE_SW_MASK  = 32'h00c0_0300;
localparam word_t EBASE_SW_MASK  = 32'h3fff_f000;
localparam word_t CONFIG_SW_MASK = 32'h0000_0007;
// Kernel mode, boot vectors, EXL and ERL clear
localparam word_t STATUS_KERNEL  = 32'h1040_0000;

task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

task automatic write_reg(input cp0_addr_t addr, input word_t value);
    next_cycle();
    we_i    = 1'b1;
    waddr_i = addr;
    data_i  = value;
    next_cycle();
    we_i = 1'b0;
endtask

task automatic read_reg(input cp0_addr_t addr, output word_t value);
    raddr_i = addr;
    #5;
    value = data_o;
endtask

// Holds the exception for one edge; vec is sampled before that edge
task automatic raise_exc(input exc_type_t t, input word_t pc, input logic ds,
                         input word_t maddr, output word_t vec);
    next_cycle();
    except_type_i   = t;
    pc_i            = pc;
    in_delay_slot_i = ds;
    mem_addr_i      = maddr;
    #5;
    vec = exception_vector_o;
    next_cycle();
    except_type_i   = EXC_NONE;
    in_delay_slot_i = 1'b0;
endtask

function automatic word_t expected_code(input exc_type_t t);
    case (t)
        EXC_SYS: return word_t'(EXCCODE_SYS);
        EXC_BP:  return word_t'(EXCCODE_BP);
        EXC_RI:  return word_t'(EXCCODE_RI);
        EXC_OV:  return word_t'(EXCCODE_OV);
        default: return word_t'(EXCCODE_TR);
    endcase
endfunction

task automatic test_reset_values();
    word_t v;
    read_reg(CP0_STATUS, v);
    check_eq("reset status", STATUS_RESET, v);
    read_reg(CP0_CONFIG, v);
    check_eq("reset config", CONFIG_RESET, v);
    read_reg(CP0_CONFIG1, v);
    check_eq("reset config1", CONFIG1_VALUE, v);
    read_reg(CP0_PRID, v);
    check_eq("reset prid", PRID, v);
    read_reg(CP0_EBASE, v);
    check_eq("reset ebase", EBASE_RESET, v);
    check_eq("reset vector", BOOT_BASE + 32'h180, exception_vector_o);
    check_eq("reset user mode", 32'd0, 32'(user_mode_o));
endtask

task automatic test_write_masks();
    word_t prior;
    word_t d;
    word_t v;
    logic [5:0] irq;
    for (int i = 0; i < 3; i++) begin
        d = (i == 0) ? 32'hffff_ffff : $urandom;
        read_reg(CP0_STATUS, prior);
        write_reg(CP0_STATUS, d);
        read_reg(CP0_STATUS, v);
        check_eq("status mask", (prior & ~STATUS_SW_MASK) | (d & STATUS_SW_MASK), v);
        read_reg(CP0_CAUSE, prior);
        write_reg(CP0_CAUSE, d);
        read_reg(CP0_CAUSE, v);
        check_eq("cause mask", (prior & ~CAUSE_SW_MASK) | (d & CAUSE_SW_MASK), v);
        write_reg(CP0_EPC, d);
        read_reg(CP0_EPC, v);
        check_eq("epc write", d, v);
        read_reg(CP0_EBASE, prior);
        write_reg(CP0_EBASE, d);
        read_reg(CP0_EBASE, v);
        check_eq("ebase mask", (prior & ~EBASE_SW_MASK) | (d & EBASE_SW_MASK), v);
        read_reg(CP0_CONFIG, prior);
        write_reg(CP0_CONFIG, d);
        read_reg(CP0_CONFIG, v);
        check_eq("config mask", (prior & ~CONFIG_SW_MASK) | (d & CONFIG_SW_MASK), v);
    end
    next_cycle();
    // At least one line set so the delay is visible
    irq   = 6'($urandom) | 6'h01;
    int_i = irq;
    read_reg(CP0_CAUSE, v);
    check_eq("cause ip hw delay", 32'd0, 32'(v[15:10]));
    next_cycle();
    read_reg(CP0_CAUSE, v);
    check_eq("cause ip hw", 32'(irq), 32'(v[15:10]));
    int_i = '0;
endtask

task automatic test_timer();
    word_t v;
    int n;
    write_reg(CP0_COMPARE, 32'd20);
    write_reg(CP0_COUNT, 32'd0);
    n = 0;
    while (!timer_int_o && n < 100) begin
        next_cycle();
        n++;
    end
    if (!timer_int_o) begin
        $display("Timeout: timer interrupt never rose");
        timeouts++;
    end
    read_reg(CP0_CAUSE, v);
    check_eq("cause ti", 32'd1, 32'(v[30]));
    write_reg(CP0_COMPARE, 32'hffff_0000);
    check_eq("timer clear", 32'd0, 32'(timer_int_o));
    read_reg(CP0_COMPARE, v);
    check_eq("compare read", 32'hffff_0000, v);
    write_reg(CP0_COUNT, 32'd0);
    repeat (7) next_cycle();
    read_reg(CP0_COUNT, v);
    check_eq("count value", 32'd7, v);
endtask

task automatic test_exception_entry();
    exc_type_t kinds[5] = '{EXC_SYS, EXC_BP, EXC_RI, EXC_OV, EXC_TR};
    exc_type_t t;
    word_t pc;
    word_t vec;
    word_t first_epc;
    for (int i = 0; i < 6; i++) begin
        write_reg(CP0_STATUS, STATUS_KERNEL);
        t  = kinds[$urandom % 5];
        pc = $urandom & 32'hffff_fffc;
        raise_exc(t, pc, i[0], 32'd0, vec);
        check_eq("exc vector", BOOT_BASE + 32'h180, vec);
        check_eq("exc epc", i[0] ? pc - 32'd4 : pc, epc_o);
        check_eq("exc bd", 32'(i[0]), 32'(cause_o[31]));
        check_eq("exc code", expected_code(t), 32'(cause_o[6:2]));
        check_eq("exc exl", 32'd1, 32'(status_o[1]));
    end
    // Second exception while EXL is still set
    first_epc = epc_o;
    raise_exc(EXC_SYS, $urandom & 32'hffff_fffc, 1'b0, 32'd0, vec);
    check_eq("nested epc", first_epc, epc_o);
    check_eq("nested code", word_t'(EXCCODE_SYS), 32'(cause_o[6:2]));
endtask

task automatic test_addr_error_eret();
    word_t pc;
    word_t ma;
    word_t vec;
    word_t v;
    pc = $urandom;
    raise_exc(EXC_ADEL_INST, pc, 1'b0, 32'd0, vec);
    read_reg(CP0_BADVADDR, v);
    check_eq("adel inst badvaddr", pc, v);
    check_eq("adel code", word_t'(EXCCODE_ADEL), 32'(cause_o[6:2]));
    ma = $urandom;
    raise_exc(EXC_ADEL_DATA, 32'h0040_0000, 1'b0, ma, vec);
    read_reg(CP0_BADVADDR, v);
    check_eq("adel data badvaddr", ma, v);
    ma = $urandom;
    raise_exc(EXC_ADES, 32'h0040_0000, 1'b0, ma, vec);
    read_reg(CP0_BADVADDR, v);
    check_eq("ades badvaddr", ma, v);
    check_eq("ades code", word_t'(EXCCODE_ADES), 32'(cause_o[6:2]));
    pc = $urandom & 32'hffff_fffc;
    write_reg(CP0_EPC, pc);
    raise_exc(EXC_ERET, 32'd0, 1'b0, 32'd0, vec);
    check_eq("eret vector", pc, vec);
    check_eq("eret exl", 32'd0, 32'(status_o[1]));
endtask

task automatic test_vector_user_mode();
    word_t d;
    word_t eb;
    word_t vec;
    d = $urandom;
    // Only the base field moves away from its reset value
    eb = (EBASE_RESET & ~EBASE_SW_MASK) | (d & EBASE_SW_MASK);
    write_reg(CP0_STATUS, 32'h1000_0000);
    write_reg(CP0_EBASE, d);
    check_eq("ebase vector", (eb & 32'hffff_f000) + 32'h180, exception_vector_o);
    write_reg(CP0_CAUSE, 32'h0080_0000);
    raise_exc(EXC_INT, 32'h0040_0000, 1'b0, 32'd0, vec);
    check_eq("iv vector", (eb & 32'hffff_f000) + 32'h200, vec);
    write_reg(CP0_STATUS, 32'h1000_0010);
    check_eq("user mode on", 32'd1, 32'(user_mode_o));
    write_reg(CP0_STATUS, 32'h1000_0012);
    check_eq("user mode exl", 32'd0, 32'(user_mode_o));
    write_reg(CP0_STATUS, 32'h1000_0014);
    check_eq("user mode erl", 32'd0, 32'(user_mode_o));
endtask

// File: bench/cp0_tb.sv
module cp0_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import cp0_reg_pkg::*;
    import cp0_exc_pkg::*;

    localparam word_t PRID      = 32'h0001_8000;
    localparam word_t BOOT_BASE = 32'hbfc0_0200;
    localparam int unsigned SEED = 32'hce686bf1;

    logic       clk;
    logic       rst;
    logic [5:0] int_i;
    logic       we_i;
    cp0_addr_t  waddr_i;
    cp0_addr_t  raddr_i;
    word_t      data_i;
    exc_type_t  except_type_i;
    word_t      pc_i;
    logic       in_delay_slot_i;
    word_t      mem_addr_i;
    word_t      data_o;
    word_t      status_o;
    word_t      cause_o;
    word_t      epc_o;
    word_t      exception_vector_o;
    logic       user_mode_o;
    logic       timer_int_o;

    int errors;
    int timeouts;

    cp0_top #(
        .PRID_VALUE    (PRID),
        .BOOT_EXC_BASE (BOOT_BASE)
    ) cp0_top_inst (
        .clk                (clk),
        .rst                (rst),
        .int_i              (int_i),
        .we_i               (we_i),
        .waddr_i            (waddr_i),
        .raddr_i            (raddr_i),
        .data_i             (data_i),
        .except_type_i      (except_type_i),
        .pc_i               (pc_i),
        .in_delay_slot_i    (in_delay_slot_i),
        .mem_addr_i         (mem_addr_i),
        .data_o             (data_o),
        .status_o           (status_o),
        .cause_o            (cause_o),
        .epc_o              (epc_o),
        .exception_vector_o (exception_vector_o),
        .user_mode_o        (user_mode_o),
        .timer_int_o        (timer_int_o)
    );

    always #50 clk = ~clk;

    task automatic check_eq(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected %08h, actual %08h", name, expected, actual);
            errors++;
        end
    endtask

    `include "cp0_tb_tasks.svh"

    initial begin
        void'($urandom(SEED));
        errors          = 0;
        timeouts        = 0;
        clk             = 1'b0;
        rst             = 1'b1;
        int_i           = '0;
        we_i            = 1'b0;
        waddr_i         = '0;
        raddr_i         = '0;
        data_i          = '0;
        except_type_i   = EXC_NONE;
        pc_i            = '0;
        in_delay_slot_i = 1'b0;
        mem_addr_i      = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset_values();
        test_write_masks();
        test_timer();
        test_exception_entry();
        test_addr_error_eret();
        test_vector_user_mode();

        $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: cp0.f
+incdir+bench
logic/cp0_reg_pkg.sv
logic/cp0_exc_pkg.sv
logic/cp0_timer.sv
logic/cp0_status_cause.sv
logic/cp0_config_regs.sv
logic/cp0_read_mux.sv
logic/cp0_vector.sv
logic/cp0_top.sv
bench/cp0_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module cp0_tb -f cp0.f -o cp0_sim
	out=$$(./obj_dir/cp0_sim); echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir
